/* cpu_isa_pkg.sv */
package cpu_isa_pkg;

	// One machine byte, for data, addresses and instruction bytes
	typedef logic [7:0] byte_t;

	// Register code inside an instruction
	typedef logic [3:0] reg_code_t;

	// Codes 0 to 7 name REG0 to REG7, 10 names RFL
	localparam reg_code_t REG_RAX = 4'd9;

	// Instruction opcodes, first byte of every instruction
	typedef enum logic [7:0] {
		OP_HALT = 8'h00,
		OP_NOOP = 8'h01,
		OP_JUMP = 8'h03,
		OP_MATH = 8'h04,
		OP_LDFM = 8'h05,
		OP_LDFI = 8'h06,
		OP_STOM = 8'h09,
		OP_JINZ = 8'h0a,
		OP_JIEQ = 8'h0b,
		OP_JILT = 8'h0c,
		OP_JIGT = 8'h0d
	} opcode_e;

	// ALU operation in the low seven bits of the operation byte
	// Bit 7 of that byte asks for a signed comparison
	typedef enum logic [6:0] {
		ALU_ADD = 7'd0,
		ALU_SUB = 7'd1,
		ALU_AND = 7'd2,
		ALU_OR  = 7'd3,
		ALU_XOR = 7'd4
	} alu_op_e;

	// Bit positions inside RFL
	localparam int unsigned FLAG_CARRY = 0;
	localparam int unsigned FLAG_EQUAL = 1;
	localparam int unsigned FLAG_LESS  = 2;
	localparam int unsigned FLAG_ZERO  = 3;

endpackage

/* cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

	// Internal bus source
	// Values 0 to 7 match the register codes
	typedef enum logic [3:0] {
		SEL_REG0    = 4'd0,
		SEL_REG1    = 4'd1,
		SEL_REG2    = 4'd2,
		SEL_REG3    = 4'd3,
		SEL_REG4    = 4'd4,
		SEL_REG5    = 4'd5,
		SEL_REG6    = 4'd6,
		SEL_REG7    = 4'd7,
		SEL_DATA_IN = 4'd8,
		SEL_RAX     = 4'd9,
		SEL_RFL     = 4'd10,
		SEL_RAM     = 4'd11,
		SEL_RIP     = 4'd12,
		SEL_RIP1    = 4'd13,
		SEL_ZERO    = 4'd14
	} bus_sel_e;

	// Front panel states first, then fetch and one state per opcode
	typedef enum logic [4:0] {
		ST_LOAD_ADDR,
		ST_LOAD_ADDR_WAIT,
		ST_LOAD_DATA,
		ST_LOAD_DATA_WAIT,
		ST_PRE_EXECUTE,
		ST_FETCH,
		ST_INC_RIP,
		ST_HALT,
		ST_NOOP,
		ST_JUMP,
		ST_MATH,
		ST_LDFM,
		ST_LDFI,
		ST_STOM,
		ST_JINZ,
		ST_JIEQ,
		ST_JILT,
		ST_JIGT
	} seq_state_e;

	// Step within a state that holds at 7 once reached
	typedef logic [2:0] step_t;

endpackage

/* cpu_alu.sv */
`timescale 1ns/1ns

module cpu_alu
	import cpu_isa_pkg::*;
(
	input  byte_t i_a,
	input  byte_t i_b,
	input  byte_t i_op_byte,
	output byte_t o_result,
	output byte_t o_flags
);

	alu_op_e    op;
	logic       is_signed;
	logic [8:0] sum;
	logic [8:0] diff;
	logic       carry;
	logic       less;

	assign op        = alu_op_e'(i_op_byte[6:0]);
	assign is_signed = i_op_byte[7];
	assign sum       = {1'b0, i_a} + {1'b0, i_b};
	// Top bit of the difference is the borrow
	assign diff      = {1'b0, i_a} - {1'b0, i_b};
	assign less      = is_signed ? ($signed(i_a) < $signed(i_b)) : (i_a < i_b);

	always_comb begin
		carry = 1'b0;
		case (op)
			ALU_ADD: begin
				o_result = sum[7:0];
				carry    = sum[8];
			end
			ALU_SUB: begin
				o_result = diff[7:0];
				carry    = diff[8];
			end
			ALU_AND: o_result = i_a & i_b;
			ALU_OR:  o_result = i_a | i_b;
			ALU_XOR: o_result = i_a ^ i_b;
			default: o_result = '0;
		endcase
	end

	always_comb begin
		o_flags             = '0;
		o_flags[FLAG_CARRY] = carry;
		o_flags[FLAG_EQUAL] = (i_a == i_b);
		o_flags[FLAG_LESS]  = less;
		o_flags[FLAG_ZERO]  = (o_result == 8'd0);
	end

endmodule

/* cpu_regfile.sv */
`timescale 1ns/1ns

module cpu_regfile
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_reset,
	input  byte_t     i_bus,
	input  bus_sel_e  i_bus_sel,
	input  logic      i_reg_we,
	input  reg_code_t i_reg_wsel,
	input  logic      i_load_alu,
	input  byte_t     i_alu_result,
	input  byte_t     i_alu_flags,
	output byte_t     o_reg_rdata,
	output byte_t     o_rax,
	output byte_t     o_rfl
);

	byte_t gpr [8];
	byte_t rax_q;
	byte_t rfl_q;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < 8; i++) begin
				gpr[i] <= '0;
			end
			rax_q <= '0;
			rfl_q <= '0;
		end else if (i_load_alu) begin
			rax_q <= i_alu_result;
			rfl_q <= i_alu_flags;
		end else if (i_reg_we) begin
			// RFL and unused codes are not writable from the bus
			if (i_reg_wsel < 4'd8) begin
				gpr[i_reg_wsel[2:0]] <= i_bus;
			end else if (i_reg_wsel == REG_RAX) begin
				rax_q <= i_bus;
			end
		end
	end

	always_comb begin
		case (i_bus_sel)
			SEL_REG0, SEL_REG1, SEL_REG2, SEL_REG3,
			SEL_REG4, SEL_REG5, SEL_REG6, SEL_REG7: o_reg_rdata = gpr[i_bus_sel[2:0]];
			SEL_RAX: o_reg_rdata = rax_q;
			SEL_RFL: o_reg_rdata = rfl_q;
			default: o_reg_rdata = '0;
		endcase
	end

	assign o_rax = rax_q;
	assign o_rfl = rfl_q;

endmodule

/* cpu_datapath.sv */
`timescale 1ns/1ns

module cpu_datapath
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	input  byte_t    i_data_in,
	input  bus_sel_e i_bus_sel,
	input  logic     i_load_mar,
	input  logic     i_load_rip,
	input  logic     i_write_ram,
	input  byte_t    i_reg_rdata,
	output byte_t    o_bus,
	output byte_t    o_ram_q
);

	byte_t mar_q;
	byte_t rip_q;
	byte_t ram_q;
	byte_t mem [256];

	// Internal bus source
	always_comb begin
		case (i_bus_sel)
			SEL_REG0, SEL_REG1, SEL_REG2, SEL_REG3,
			SEL_REG4, SEL_REG5, SEL_REG6, SEL_REG7,
			SEL_RAX, SEL_RFL: o_bus = i_reg_rdata;
			SEL_DATA_IN:      o_bus = i_data_in;
			SEL_RAM:          o_bus = ram_q;
			SEL_RIP:          o_bus = rip_q;
			SEL_RIP1:         o_bus = rip_q + 8'd1;
			default:          o_bus = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			mar_q <= '0;
			rip_q <= '0;
		end else begin
			if (i_load_mar) begin
				mar_q <= o_bus;
			end
			if (i_load_rip) begin
				rip_q <= o_bus;
			end
		end
	end

	// Single port RAM whose read data follows MAR by one clock
	always_ff @(posedge i_clk) begin
		if (i_write_ram) begin
			mem[mar_q] <= o_bus;
		end
		ram_q <= mem[mar_q];
	end

	assign o_ram_q = ram_q;

endmodule

/* cpu_decode.sv */
`timescale 1ns/1ns

module cpu_decode
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_reset,
	input  logic      i_load_addr,
	input  logic      i_load_data,
	input  logic      i_execute,
	input  byte_t     i_ram_q,
	input  byte_t     i_flags,
	output bus_sel_e  o_bus_sel,
	output logic      o_load_mar,
	output logic      o_load_rip,
	output logic      o_write_ram,
	output logic      o_load_alu,
	output logic      o_reg_we,
	output reg_code_t o_reg_wsel,
	output logic      o_waiting,
	output logic      o_take_input
);

	seq_state_e state_q;
	seq_state_e state_d;
	step_t      step_q;
	reg_code_t  code_q;
	logic       code_load;
	logic       branch_taken;

	// Unknown opcodes halt the machine
	function automatic seq_state_e dispatch(input byte_t op);
		case (opcode_e'(op))
			OP_NOOP: return ST_NOOP;
			OP_JUMP: return ST_JUMP;
			OP_MATH: return ST_MATH;
			OP_LDFM: return ST_LDFM;
			OP_LDFI: return ST_LDFI;
			OP_STOM: return ST_STOM;
			OP_JINZ: return ST_JINZ;
			OP_JIEQ: return ST_JIEQ;
			OP_JILT: return ST_JILT;
			OP_JIGT: return ST_JIGT;
			default: return ST_HALT;
		endcase
	endfunction

	always_comb begin
		case (state_q)
			ST_JINZ: branch_taken = !i_flags[FLAG_ZERO];
			ST_JIEQ: branch_taken = i_flags[FLAG_EQUAL];
			ST_JILT: branch_taken = i_flags[FLAG_LESS];
			ST_JIGT: branch_taken = !(i_flags[FLAG_LESS] || i_flags[FLAG_EQUAL]);
			default: branch_taken = 1'b0;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_LOAD_ADDR: begin
				if (i_load_addr) begin
					state_d = ST_LOAD_ADDR_WAIT;
				end else if (i_execute) begin
					state_d = ST_PRE_EXECUTE;
				end
			end
			ST_LOAD_ADDR_WAIT: state_d = i_load_addr ? ST_LOAD_ADDR_WAIT : ST_LOAD_DATA;
			ST_LOAD_DATA:      state_d = i_load_data ? ST_LOAD_DATA_WAIT : ST_LOAD_DATA;
			ST_LOAD_DATA_WAIT: state_d = i_load_data ? ST_LOAD_DATA_WAIT : ST_LOAD_ADDR;
			ST_PRE_EXECUTE:    state_d = i_execute ? ST_PRE_EXECUTE : ST_FETCH;
			ST_FETCH, ST_INC_RIP: begin
				if (step_q == step_t'(2)) begin
					state_d = dispatch(i_ram_q);
				end
			end
			ST_HALT: state_d = ST_LOAD_ADDR;
			ST_NOOP: state_d = ST_INC_RIP;
			ST_JUMP: begin
				if (step_q == step_t'(2)) begin
					state_d = ST_FETCH;
				end
			end
			ST_MATH, ST_LDFI: begin
				if (step_q == step_t'(3)) begin
					state_d = ST_INC_RIP;
				end
			end
			ST_STOM: begin
				if (step_q == step_t'(4)) begin
					state_d = ST_INC_RIP;
				end
			end
			ST_LDFM: begin
				if (step_q == step_t'(5)) begin
					state_d = ST_INC_RIP;
				end
			end
			// Not taken leaves RIP on the operand, INC_RIP steps past it
			ST_JINZ, ST_JIEQ, ST_JILT, ST_JIGT: begin
				if (step_q == step_t'(0) && !branch_taken) begin
					state_d = ST_INC_RIP;
				end else if (step_q == step_t'(2)) begin
					state_d = ST_FETCH;
				end
			end
			default: state_d = ST_HALT;
		endcase
	end

	always_comb begin
		o_bus_sel    = SEL_DATA_IN;
		o_load_mar   = 1'b0;
		o_load_rip   = 1'b0;
		o_write_ram  = 1'b0;
		o_load_alu   = 1'b0;
		o_reg_we     = 1'b0;
		o_waiting    = 1'b0;
		o_take_input = 1'b0;
		code_load    = 1'b0;
		case (state_q)
			ST_LOAD_ADDR: begin
				o_load_mar = 1'b1;
				o_waiting  = 1'b1;
			end
			ST_LOAD_DATA: begin
				o_write_ram  = 1'b1;
				o_take_input = 1'b1;
			end
			ST_PRE_EXECUTE: begin
				o_bus_sel  = SEL_ZERO;
				o_load_rip = 1'b1;
				o_load_mar = 1'b1;
			end
			ST_FETCH: begin
				if (step_q == step_t'(0)) begin
					o_bus_sel  = SEL_RIP;
					o_load_mar = 1'b1;
				end
			end
			ST_INC_RIP: begin
				if (step_q == step_t'(0)) begin
					o_bus_sel  = SEL_RIP1;
					o_load_rip = 1'b1;
					o_load_mar = 1'b1;
				end
			end
			// Branches also move RIP onto the operand in step 0
			ST_JUMP, ST_JINZ, ST_JIEQ, ST_JILT, ST_JIGT: begin
				if (step_q == step_t'(0)) begin
					o_bus_sel  = SEL_RIP1;
					o_load_mar = 1'b1;
					o_load_rip = (state_q != ST_JUMP);
				end else if (step_q == step_t'(2)) begin
					o_bus_sel  = SEL_RAM;
					o_load_rip = 1'b1;
				end
			end
			ST_MATH, ST_LDFI, ST_LDFM, ST_STOM: begin
				if (step_q <= step_t'(1)) begin
					// Walk RIP over both operand bytes
					o_bus_sel  = SEL_RIP1;
					o_load_rip = 1'b1;
					o_load_mar = 1'b1;
				end else if (step_q == step_t'(2)) begin
					// Register code of byte 1 is on the RAM output now
					code_load = 1'b1;
				end else begin
					case (state_q)
						ST_MATH: begin
							o_bus_sel  = bus_sel_e'(code_q);
							o_load_alu = 1'b1;
						end
						ST_LDFI: begin
							o_bus_sel = SEL_RAM;
							o_reg_we  = 1'b1;
						end
						ST_STOM: begin
							if (step_q == step_t'(3)) begin
								o_bus_sel  = SEL_RAM;
								o_load_mar = 1'b1;
							end else begin
								o_bus_sel   = bus_sel_e'(code_q);
								o_write_ram = 1'b1;
							end
						end
						default: begin
							// LDFM waits one step for the operand read
							o_bus_sel = SEL_RAM;
							if (step_q == step_t'(3)) begin
								o_load_mar = 1'b1;
							end else if (step_q == step_t'(5)) begin
								o_reg_we = 1'b1;
							end
						end
					endcase
				end
			end
			default: begin
				o_bus_sel = SEL_DATA_IN;
			end
		endcase
	end

	assign o_reg_wsel = code_q;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state_q <= ST_LOAD_ADDR;
			step_q  <= '0;
			code_q  <= '0;
		end else begin
			state_q <= state_d;
			if (state_d != state_q) begin
				step_q <= '0;
			end else if (step_q != step_t'(7)) begin
				step_q <= step_q + step_t'(1);
			end
			if (code_load) begin
				code_q <= reg_code_t'(i_ram_q[3:0]);
			end
		end
	end

endmodule

/* cpu_top.sv */
`timescale 1ns/1ns

module cpu_top
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_reset,
	input  logic  i_load_addr,
	input  logic  i_load_data,
	input  logic  i_execute,
	input  byte_t i_data_in,
	output byte_t o_data_out,
	output logic  o_waiting,
	output logic  o_take_input
);

	bus_sel_e  bus_sel;
	logic      load_mar;
	logic      load_rip;
	logic      write_ram;
	logic      load_alu;
	logic      reg_we;
	reg_code_t reg_wsel;
	byte_t     bus;
	byte_t     ram_q;
	byte_t     reg_rdata;
	byte_t     rax;
	byte_t     rfl;
	byte_t     alu_result;
	byte_t     alu_flags;

	// Panel readback shows the RAM output directly
	assign o_data_out = ram_q;

	cpu_decode u_decode (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_load_addr  (i_load_addr),
		.i_load_data  (i_load_data),
		.i_execute    (i_execute),
		.i_ram_q      (ram_q),
		.i_flags      (rfl),
		.o_bus_sel    (bus_sel),
		.o_load_mar   (load_mar),
		.o_load_rip   (load_rip),
		.o_write_ram  (write_ram),
		.o_load_alu   (load_alu),
		.o_reg_we     (reg_we),
		.o_reg_wsel   (reg_wsel),
		.o_waiting    (o_waiting),
		.o_take_input (o_take_input)
	);

	cpu_datapath u_datapath (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_data_in   (i_data_in),
		.i_bus_sel   (bus_sel),
		.i_load_mar  (load_mar),
		.i_load_rip  (load_rip),
		.i_write_ram (write_ram),
		.i_reg_rdata (reg_rdata),
		.o_bus       (bus),
		.o_ram_q     (ram_q)
	);

	// RAM output carries the operation byte during MATH
	cpu_alu u_alu (
		.i_a       (rax),
		.i_b       (bus),
		.i_op_byte (ram_q),
		.o_result  (alu_result),
		.o_flags   (alu_flags)
	);

	cpu_regfile u_regfile (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_bus        (bus),
		.i_bus_sel    (bus_sel),
		.i_reg_we     (reg_we),
		.i_reg_wsel   (reg_wsel),
		.i_load_alu   (load_alu),
		.i_alu_result (alu_result),
		.i_alu_flags  (alu_flags),
		.o_reg_rdata  (reg_rdata),
		.o_rax        (rax),
		.o_rfl        (rfl)
	);

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic o_clk,
	output logic o_reset
);

	// 40 ns period
	initial begin
		o_clk = 1'b0;
		forever begin
			#20 o_clk = ~o_clk;
		end
	end

	// Reset covers the first eight rising edges
	initial begin
		o_reset = 1'b1;
		repeat (8) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

/* tb_cpu_assert.sv */
`timescale 1ns/1ns

module tb_cpu_assert (
	input logic i_clk,
	input logic i_reset,
	input logic i_write_ram,
	input logic i_load_alu,
	input logic i_reg_we,
	input logic i_waiting
);

	// The ALU load uses the bus as an operand, a RAM write would use it as data
	ram_vs_alu: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_write_ram && i_load_alu))
		else $error("RAM write and ALU load in the same cycle");

	// RAX has one writer per cycle
	reg_vs_alu: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_reg_we && i_load_alu))
		else $error("register write and ALU load in the same cycle");

	waiting_after_reset: assert property (@(posedge i_clk)
		$fell(i_reset) |-> i_waiting)
		else $error("sequencer not waiting in the first cycle after reset");

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu
	import cpu_isa_pkg::*;
();

	localparam int CYCLE_LIMIT = 30000;
	localparam int RUN_LIMIT = 2000;
	localparam byte_t CODE_RAX = 8'h09;
	localparam byte_t CODE_RFL = 8'h0a;

	logic  clk;
	logic  reset;
	logic  load_addr;
	logic  load_data;
	logic  execute;
	byte_t data_in;
	byte_t data_out;
	logic  waiting;
	logic  take_input;

	// Expected RAM image, program under construction and readback records
	byte_t mem_model [256];
	byte_t prog [$];
	byte_t addr_q [$];
	byte_t exp_q [$];
	byte_t got_q [$];
	int    cmp_idx = 0;
	int    checks = 0;
	int    errors = 0;
	int    proc_errors = 0;
	int    cycles = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    base_fail = 0;
	int    base_checks = 0;
	string test_name;

	tb_clock u_clock (
		.o_clk   (clk),
		.o_reset (reset)
	);

	cpu_top uut (
		.i_clk        (clk),
		.i_reset      (reset),
		.i_load_addr  (load_addr),
		.i_load_data  (load_data),
		.i_execute    (execute),
		.i_data_in    (data_in),
		.o_data_out   (data_out),
		.o_waiting    (waiting),
		.o_take_input (take_input)
	);

	bind cpu_decode tb_cpu_assert u_assert (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_write_ram (o_write_ram),
		.i_load_alu  (o_load_alu),
		.i_reg_we    (o_reg_we),
		.i_waiting   (o_waiting)
	);

	// Result in the low byte, RFL image in the high byte
	function automatic logic [15:0] alu_ref(input byte_t a, input byte_t b, input byte_t op);
		logic [8:0] wide;
		byte_t      flags;
		flags = 8'h00;
		case (op[6:0])
			ALU_ADD: wide = {1'b0, a} + {1'b0, b};
			ALU_SUB: wide = {1'b0, a} - {1'b0, b};
			ALU_AND: wide = {1'b0, a & b};
			ALU_OR:  wide = {1'b0, a | b};
			ALU_XOR: wide = {1'b0, a ^ b};
			default: wide = 9'h000;
		endcase
		flags[FLAG_CARRY] = wide[8];
		flags[FLAG_EQUAL] = (a == b);
		flags[FLAG_LESS]  = op[7] ? ($signed(a) < $signed(b)) : (a < b);
		flags[FLAG_ZERO]  = (wide[7:0] == 8'h00);
		return {flags, wide[7:0]};
	endfunction

	function automatic logic branch_ref(input byte_t op, input byte_t flags);
		case (op)
			OP_JINZ: return !flags[FLAG_ZERO];
			OP_JIEQ: return flags[FLAG_EQUAL];
			OP_JILT: return flags[FLAG_LESS];
			OP_JIGT: return !flags[FLAG_LESS] && !flags[FLAG_EQUAL];
			default: return 1'b0;
		endcase
	endfunction

	function automatic void emit_one(input byte_t op);
		prog.push_back(op);
	endfunction

	function automatic void emit_two(input byte_t op, input byte_t first);
		prog.push_back(op);
		prog.push_back(first);
	endfunction

	function automatic void emit_three(input byte_t op, input byte_t first, input byte_t second);
		prog.push_back(op);
		prog.push_back(first);
		prog.push_back(second);
	endfunction

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the run never reached its end", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Readbacks are queued at the falling edge and compared here
	always @(posedge clk) begin
		while (cmp_idx < got_q.size()) begin
			checks++;
			if (got_q[cmp_idx] !== exp_q[cmp_idx]) begin
				errors++;
				$display("error o_data_out at %h: got %h, expected %h",
					addr_q[cmp_idx], got_q[cmp_idx], exp_q[cmp_idx]);
			end
			cmp_idx++;
		end
	end

	task automatic wait_idle();
		@(negedge clk);
		while (!waiting) begin
			@(negedge clk);
		end
	endtask

	task automatic load_byte(input byte_t addr, input byte_t value);
		wait_idle();
		@(posedge clk);
		data_in   <= addr;
		load_addr <= 1'b1;
		@(posedge clk);
		load_addr <= 1'b0;
		data_in   <= value;
		@(posedge clk);
		load_data <= 1'b1;
		@(negedge clk);
		if (take_input !== 1'b1) begin
			proc_errors++;
			$display("error o_take_input: got %h, expected %h", take_input, 1'b1);
		end
		@(posedge clk);
		load_data <= 1'b0;
		mem_model[addr] = value;
	endtask

	// MAR follows the data input after one edge, the RAM output after two
	task automatic read_byte(input byte_t addr);
		wait_idle();
		@(posedge clk);
		data_in <= addr;
		@(posedge clk);
		@(posedge clk);
		@(negedge clk);
		addr_q.push_back(addr);
		exp_q.push_back(mem_model[addr]);
		got_q.push_back(data_out);
	endtask

	task automatic run_program();
		int waited;
		waited = 0;
		for (int i = 0; i < prog.size(); i++) begin
			load_byte(byte_t'(i), prog[i]);
		end
		wait_idle();
		@(posedge clk);
		execute <= 1'b1;
		@(posedge clk);
		execute <= 1'b0;
		@(negedge clk);
		if (waiting) begin
			proc_errors++;
			$display("the execute pulse did not start the program");
		end
		while (!waiting && waited < RUN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!waiting) begin
			proc_errors++;
			$display("program did not return to waiting within %0d cycles", RUN_LIMIT);
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		base_fail   = errors + proc_errors;
		base_checks = checks;
		prog.delete();
	endtask

	task automatic end_test();
		int fails;
		while (cmp_idx < got_q.size()) begin
			@(negedge clk);
		end
		fails = errors + proc_errors - base_fail;
		tests_run++;
		if (fails != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %0d checks, %0d errors, %s", tests_run, test_name,
			checks - base_checks, fails, (fails == 0) ? "ok" : "failed");
	endtask

	task automatic test_reset_halt();
		begin_test("reset state and halt");
		@(negedge reset);
		@(negedge clk);
		if (waiting !== 1'b1) begin
			proc_errors++;
			$display("error o_waiting: got %h, expected %h", waiting, 1'b1);
		end
		if (take_input !== 1'b0) begin
			proc_errors++;
			$display("error o_take_input: got %h, expected %h", take_input, 1'b0);
		end
		emit_one(OP_HALT);
		run_program();
		end_test();
	endtask

	task automatic test_panel();
		byte_t addrs [32];
		begin_test("panel load and readback");
		for (int i = 0; i < 32; i++) begin
			addrs[i] = 8'($urandom());
			load_byte(addrs[i], 8'($urandom()));
		end
		for (int i = 0; i < 32; i++) begin
			read_byte(addrs[i]);
		end
		end_test();
	endtask

	task automatic test_load_store();
		byte_t code;
		byte_t imm;
		begin_test("immediate load and store");
		// REG0 to REG7, then RAX
		for (int i = 0; i < 9; i++) begin
			code = (i < 8) ? 8'(i) : CODE_RAX;
			imm  = 8'($urandom());
			emit_three(OP_LDFI, code, imm);
			mem_model[8'hc0 + 8'(i)] = imm;
		end
		for (int i = 0; i < 9; i++) begin
			code = (i < 8) ? 8'(i) : CODE_RAX;
			emit_three(OP_STOM, code, 8'hc0 + 8'(i));
		end
		emit_one(OP_HALT);
		run_program();
		for (int i = 0; i < 9; i++) begin
			read_byte(8'hc0 + 8'(i));
		end
		end_test();
	endtask

	task automatic test_math();
		byte_t       a;
		byte_t       b;
		byte_t       opb;
		byte_t       out;
		logic [15:0] r;
		begin_test("math and flags");
		for (int i = 0; i < 10; i++) begin
			a = 8'($urandom());
			b = 8'($urandom());
			// Equal operands on SUB once per signedness
			if (i % 5 == 1) begin
				b = a;
			end
			opb = {i >= 5, 7'(i % 5)};
			out = 8'(8'hc0 + 2 * i);
			emit_three(OP_LDFI, CODE_RAX, a);
			emit_three(OP_LDFI, 8'h03, b);
			emit_three(OP_MATH, 8'h03, opb);
			emit_three(OP_STOM, CODE_RAX, out);
			emit_three(OP_STOM, CODE_RFL, out + 8'h01);
			r = alu_ref(a, b, opb);
			mem_model[out]         = r[7:0];
			mem_model[out + 8'h01] = r[15:8];
		end
		emit_one(OP_HALT);
		run_program();
		for (int i = 0; i < 20; i++) begin
			read_byte(8'(8'hc0 + i));
		end
		end_test();
	endtask

	task automatic test_branch();
		byte_t       br_ops [4];
		byte_t       a;
		byte_t       b;
		byte_t       opb;
		byte_t       out;
		int          base;
		logic [15:0] r;
		begin_test("conditional branches");
		br_ops[0] = OP_JINZ;
		br_ops[1] = OP_JIEQ;
		br_ops[2] = OP_JILT;
		br_ops[3] = OP_JIGT;
		for (int t = 0; t < 2; t++) begin
			for (int k = 0; k < 4; k++) begin
				a = 8'($urandom());
				b = 8'($urandom());
				// Second pass is signed and makes JINZ and JIEQ see equal operands
				if (t == 1 && k < 2) begin
					b = a;
				end
				opb  = {t == 1, ALU_SUB};
				out  = 8'(8'he0 + 4 * t + k);
				base = prog.size();
				emit_three(OP_LDFI, CODE_RAX, a);
				emit_three(OP_LDFI, 8'h03, b);
				emit_three(OP_MATH, 8'h03, opb);
				emit_two(br_ops[k], 8'(base + 19));
				emit_three(OP_LDFI, 8'h01, 8'h55);
				emit_three(OP_STOM, 8'h01, out);
				emit_two(OP_JUMP, 8'(base + 25));
				// Branch target
				emit_three(OP_LDFI, 8'h01, 8'haa);
				emit_three(OP_STOM, 8'h01, out);
				r = alu_ref(a, b, opb);
				mem_model[out] = branch_ref(br_ops[k], r[15:8]) ? 8'haa : 8'h55;
			end
		end
		emit_one(OP_HALT);
		run_program();
		for (int i = 0; i < 8; i++) begin
			read_byte(8'(8'he0 + i));
		end
		end_test();
	endtask

	task automatic test_copy_jump();
		byte_t value;
		byte_t orig;
		begin_test("memory load, noop and jump");
		value = 8'($urandom());
		orig  = 8'($urandom());
		load_byte(8'hf0, value);
		load_byte(8'hf8, orig);
		emit_one(OP_NOOP);
		emit_three(OP_LDFM, 8'h05, 8'hf0);
		emit_three(OP_STOM, 8'h05, 8'hf4);
		// Lands on the HALT behind the poison store
		emit_two(OP_JUMP, 8'(prog.size() + 8));
		emit_three(OP_LDFI, 8'h06, ~orig);
		emit_three(OP_STOM, 8'h06, 8'hf8);
		emit_one(OP_HALT);
		mem_model[8'hf4] = value;
		run_program();
		read_byte(8'hf4);
		read_byte(8'hf8);
		end_test();
	endtask

	initial begin
		load_addr = 1'b0;
		load_data = 1'b0;
		execute   = 1'b0;
		data_in   = 8'h00;
		void'($urandom(32'hbba0a6be));
		test_reset_halt();
		test_panel();
		test_load_store();
		test_math();
		test_branch();
		test_copy_jump();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors + proc_errors);
		if (errors + proc_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* all.f */
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
cpu_alu.sv
cpu_regfile.sv
cpu_datapath.sv
cpu_decode.sv
cpu_top.sv
tb_clock.sv
tb_cpu_assert.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
